//--- include/painter_defines.svh
// Calculator painter geometry
`ifndef PAINTER_DEFINES_SVH
`define PAINTER_DEFINES_SVH

// ------------------------------------------------------------------------
// Screen and coordinates
// ------------------------------------------------------------------------
`define PIX_W          10   // Pixel coordinate width

// ------------------------------------------------------------------------
// Keypad grid
// ------------------------------------------------------------------------
`define GRID_X0        175  // Grid origin x
`define GRID_Y0        190  // Grid origin y
`define CELL           63   // Cell pitch in both directions
`define VBAR_SPAN      3    // Vertical bar band, open interval
`define HBAR_SPAN      2    // Horizontal bar band, one line thick

// Colour boundary three cells in from the left edge
`define GRID_SPLIT_X   (`GRID_X0 + 3 * `CELL)

// ------------------------------------------------------------------------
// Font ROM
// ------------------------------------------------------------------------
`define FONT_ROW_W     4    // Row index inside a glyph
`define FONT_BIT_W     3    // Bit index inside a font row
`define CHAR_W         7    // Character code width
`define ROM_ADDR_W     11   // Char code plus row index

// ------------------------------------------------------------------------
// Tiles and cursor
// ------------------------------------------------------------------------
`define NUM_DIGITS     10   // Readout length
`define READOUT_ROW    1    // Tile row of the readout
`define READOUT_COL0   14   // Rightmost readout column, digit 0
`define KEY_ROW0       3    // Top keypad tile row

`define CURSOR_SIZE    5    // Mouse box edge

`endif

//--- source/glyph_pkg.sv
// Glyph and character code types
`include "painter_defines.svh"

package glyph_pkg;

	// Font ROM character code, ASCII based
	typedef logic [`CHAR_W-1:0] char_code_t;

	// Operator keys as they appear on screen
	// Codes are the ASCII of the painted symbol
	typedef enum logic [`CHAR_W-1:0]
	{
		op_mul = 7'h78,  // 'x'
		op_div = 7'h25,  // '%' used as divide sign
		op_add = 7'h2b,  // '+'
		op_sub = 7'h2d,  // '-'
		op_eq  = 7'h3d   // '='
	} op_glyph_t;

	// Code of '0', digits follow in order
	localparam char_code_t DIGIT_BASE = 7'h30;

endpackage

//--- source/color_pkg.sv
// Colour and pixel class types
package color_pkg;

	// 3-bit RGB, one bit per gun
	// Only the five painted colours are named
	typedef enum logic [2:0]
	{
		black      = 3'b000,
		green      = 3'b010,  // Cursor
		light_blue = 3'b011,  // Bars left of split
		pink       = 3'b101,  // Bars right of split
		white      = 3'b111   // Glyph foreground
	} rgb_t;

	// What a pixel belongs to, after priority
	typedef enum logic [2:0]
	{
		px_back,       // Nothing drawn
		px_cursor,     // Mouse box, wins over all
		px_bar_left,   // Grid bar, left zone
		px_bar_right,  // Grid bar, right zone
		px_glyph       // Inside a character tile
	} pixel_class_t;

endpackage

//--- source/grid_bars.sv
// Keypad grid bar hit test
`include "painter_defines.svh"

module grid_bars
(
	input  logic [`PIX_W-1:0]  pix_x,
	input  logic [`PIX_W-1:0]  pix_y,
	output logic               bar_on,          // Any of the eleven bars
	output logic               bar_right_zone   // Pixel at or past the split
);

	localparam logic [`PIX_W-1:0] x0        = `PIX_W'(`GRID_X0);
	localparam logic [`PIX_W-1:0] y0        = `PIX_W'(`GRID_Y0);
	localparam logic [`PIX_W-1:0] vbar_span = `PIX_W'(`VBAR_SPAN);
	localparam logic [`PIX_W-1:0] hbar_span = `PIX_W'(`HBAR_SPAN);
	localparam logic [`PIX_W-1:0] split_x   = `PIX_W'(`GRID_SPLIT_X);

	logic [5:0] vbar_hit;
	logic [4:0] hbar_hit;

	// ------------------------------------------------------------------------
	// Vertical bars, one per cell edge
	// ------------------------------------------------------------------------
	for (genvar k = 0; k < 6; k++)
	begin : g_vbar
		// Two leftmost bars reach the zero key row
		localparam logic [`PIX_W-1:0] x_start = `PIX_W'(`GRID_X0 + k * `CELL);
		localparam logic [`PIX_W-1:0] y_end   =
			`PIX_W'(`GRID_Y0 + ((k < 2) ? 4 : 3) * `CELL);

		assign vbar_hit[k] = (pix_x > x_start) && (pix_x < x_start + vbar_span) &&
			(pix_y > y0) && (pix_y < y_end);
	end

	// ------------------------------------------------------------------------
	// Horizontal bars, single line at start plus one
	// ------------------------------------------------------------------------
	for (genvar k = 0; k < 5; k++)
	begin : g_hbar
		localparam logic [`PIX_W-1:0] y_start = `PIX_W'(`GRID_Y0 + k * `CELL);
		// Bottom bar only closes the zero key
		localparam logic [`PIX_W-1:0] x_end   = (k == 4) ?
			`PIX_W'(`GRID_X0 + `CELL + `HBAR_SPAN) : `PIX_W'(`GRID_X0 + 5 * `CELL);

		assign hbar_hit[k] = (pix_y > y_start) && (pix_y < y_start + hbar_span) &&
			(pix_x > x0) && (pix_x < x_end);
	end

	assign bar_on         = |vbar_hit || |hbar_hit;
	assign bar_right_zone = (pix_x >= split_x);  // Colour boundary

	// Bands narrower than a cell, so bars of one direction never overlap
	always_comb
	begin
		assert final ($onehot0(vbar_hit) && $onehot0(hbar_hit))
			else $error("grid_bars: overlapping bars at x=%h y=%h", pix_x, pix_y);
	end

endmodule

//--- source/glyph_map.sv
// Keypad and readout character lookup
`include "painter_defines.svh"

module glyph_map
	import glyph_pkg::*;
(
	input  logic [`PIX_W-1:0]         pix_x,
	input  logic [`PIX_W-1:0]         pix_y,
	input  logic [4*`NUM_DIGITS-1:0]  num_actual,     // BCD readout value
	input  logic [3:0]                counter_total,  // Digits to show
	output logic                      glyph_on,
	output char_code_t                char_code
);

	// Tiles are 32 wide, 64 high
	logic [4:0]  tile_col;
	logic [3:0]  tile_row;
	logic [3:0]  key_row;        // Row within keypad
	logic        key_on;
	logic        read_on;
	char_code_t  key_code;
	char_code_t  read_code;

	assign tile_col = pix_x[9:5];
	assign tile_row = pix_y[9:6];
	assign key_row  = tile_row - 4'(`KEY_ROW0);  // Wraps above keypad, hits default

	function automatic char_code_t digit_code(input logic [3:0] d);
		return DIGIT_BASE + char_code_t'(d);
	endfunction

	// ------------------------------------------------------------------------
	// Keypad, phone layout with operators on the right
	// ------------------------------------------------------------------------
	always_comb
	begin
		key_on   = 1'b1;
		key_code = '0;
		case (key_row)
			4'd0:
			begin
				case (tile_col)
					5'd6:    key_code = digit_code(4'd7);
					5'd8:    key_code = digit_code(4'd8);
					5'd10:   key_code = digit_code(4'd9);
					5'd12:   key_code = op_mul;
					5'd14:   key_code = op_div;
					default: key_on   = 1'b0;
				endcase
			end
			4'd1:
			begin
				case (tile_col)
					5'd6:    key_code = digit_code(4'd4);
					5'd8:    key_code = digit_code(4'd5);
					5'd10:   key_code = digit_code(4'd6);
					5'd12:   key_code = op_add;
					5'd14:   key_code = op_sub;
					default: key_on   = 1'b0;
				endcase
			end
			4'd2:
			begin
				case (tile_col)
					5'd6:    key_code = digit_code(4'd1);
					5'd8:    key_code = digit_code(4'd2);
					5'd10:   key_code = digit_code(4'd3);
					5'd14:   key_code = op_eq;   // No key at column 12
					default: key_on   = 1'b0;
				endcase
			end
			4'd3:
			begin
				if (tile_col == 5'd6)
					key_code = digit_code(4'd0);  // Lone zero key
				else
					key_on = 1'b0;
			end
			default: key_on = 1'b0;
		endcase
	end

	// ------------------------------------------------------------------------
	// Readout, digit 0 rightmost, grows left
	// ------------------------------------------------------------------------
	always_comb
	begin
		read_on   = 1'b0;
		read_code = '0;
		if (tile_row == 4'(`READOUT_ROW))
		begin
			for (int i = 0; i < `NUM_DIGITS; i++)
			begin
				// Unentered digits stay blank
				if ((tile_col == 5'(`READOUT_COL0 - i)) && (counter_total > 4'(i)))
				begin
					read_on   = 1'b1;
					read_code = digit_code(num_actual[4*i +: 4]);
				end
			end
		end
	end

	// Readout and keypad rows never overlap
	assign glyph_on  = key_on || read_on;
	assign char_code = read_on ? read_code : key_code;

endmodule

//--- source/pixel_classifier.sv
// Stage one pixel classification
`include "painter_defines.svh"

module pixel_classifier
	import glyph_pkg::*;
	import color_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    pixel_tick,
	input  logic [`PIX_W-1:0]       pix_x,
	input  logic [`PIX_W-1:0]       pix_y,
	input  logic [`PIX_W-1:0]       xm,
	input  logic [`PIX_W-1:0]       ym,
	input  logic                    bar_on,
	input  logic                    bar_right_zone,
	input  logic                    glyph_on,
	input  char_code_t              char_code,
	output pixel_class_t            pix_class,
	output logic [`ROM_ADDR_W-1:0]  rom_addr,      // Straight to font ROM
	output logic [`FONT_BIT_W-1:0]  font_bit_idx,  // Column inside glyph
	output logic                    tick_s1
);

	localparam logic [`PIX_W:0] cursor_span = (`PIX_W + 1)'(`CURSOR_SIZE);

	logic [`PIX_W:0]          xm_end;   // One extra bit, no wrap at right edge
	logic [`PIX_W:0]          ym_end;
	logic                     cursor_on;
	pixel_class_t             class_d;
	logic [`ROM_ADDR_W-1:0]   addr_d;

	// Open box around mouse point
	assign xm_end    = {1'b0, xm} + cursor_span;
	assign ym_end    = {1'b0, ym} + cursor_span;
	assign cursor_on = (pix_x > xm) && ({1'b0, pix_x} < xm_end) &&
		(pix_y > ym) && ({1'b0, pix_y} < ym_end);

	// Cursor, then bars, then glyphs
	always_comb
	begin
		class_d = px_back;
		if (cursor_on)
			class_d = px_cursor;
		else if (bar_on)
			class_d = bar_right_zone ? px_bar_right : px_bar_left;
		else if (glyph_on)
			class_d = px_glyph;
	end

	// Glyph row from y, scaled by four
	assign addr_d = (class_d == px_glyph) ?
		{char_code, pix_y[`FONT_ROW_W+1:2]} : '0;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pix_class <= px_back;
			rom_addr  <= '0;
			tick_s1   <= 1'b0;
		end
		else
		begin
			pix_class <= class_d;
			rom_addr  <= addr_d;
			tick_s1   <= pixel_tick;
		end
	end

	// Bit index rides along with the address
	always_ff @(posedge clk)
	begin
		font_bit_idx <= pix_x[`FONT_BIT_W+1:2];
	end

	// Glyph tiles always resolve to a real character
	glyph_addr_chk: assert property (@(posedge clk) disable iff (!rst_n)
		(pix_class == px_glyph) |-> (rom_addr[`ROM_ADDR_W-1 -: `CHAR_W] != '0))
		else $error("pixel_classifier: glyph with null code, rom_addr=%h", rom_addr);

endmodule

//--- source/pixel_colorizer.sv
// Stage two colour selection
`include "painter_defines.svh"

module pixel_colorizer
	import color_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  pixel_class_t            pix_class,
	input  logic [`FONT_BIT_W-1:0]  font_bit_idx,
	input  logic                    tick_s1,
	input  logic [7:0]              font_word,   // Row for last cycle's rom_addr
	output rgb_t                    text_rgb
);

	// Aligned with font_word
	pixel_class_t            class_s2;
	logic [`FONT_BIT_W-1:0]  bit_idx_s2;
	logic                    tick_s2;

	logic  font_bit;
	rgb_t  rgb_d;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			class_s2 <= px_back;
			tick_s2  <= 1'b0;
		end
		else
		begin
			class_s2 <= pix_class;
			tick_s2  <= tick_s1;
		end
	end

	always_ff @(posedge clk)
	begin
		bit_idx_s2 <= font_bit_idx;
	end

	// Leftmost pixel is font bit 7
	assign font_bit = font_word[3'd7 - bit_idx_s2];

	always_comb
	begin
		case (class_s2)
			px_cursor:    rgb_d = green;
			px_bar_left:  rgb_d = light_blue;
			px_bar_right: rgb_d = pink;
			px_glyph:     rgb_d = font_bit ? white : black;
			default:      rgb_d = black;   // Background
		endcase
	end

	// Output only moves on qualified pixels
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			text_rgb <= black;
		else if (tick_s2)
			text_rgb <= rgb_d;
	end

	// Tick gap two cycles upstream freezes the colour
	rgb_hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
		!tick_s1 |=> ##1 $stable(text_rgb))
		else $error("pixel_colorizer: text_rgb moved without tick, now %h", text_rgb);

endmodule

//--- source/calc_painter_top.sv
// Calculator screen pixel painter
`include "painter_defines.svh"

module calc_painter_top
	import glyph_pkg::*;
	import color_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    pixel_tick,     // Pixel qualifier strobe
	input  logic [`PIX_W-1:0]       pix_x,
	input  logic [`PIX_W-1:0]       pix_y,
	input  logic [`PIX_W-1:0]       xm,             // Mouse position
	input  logic [`PIX_W-1:0]       ym,
	input  logic [39:0]             num_actual,     // BCD, nibble i is digit i
	input  logic [3:0]              counter_total,  // Digits entered so far
	input  logic [7:0]              font_word,      // From external font ROM
	output logic [`ROM_ADDR_W-1:0]  rom_addr,
	output rgb_t                    text_rgb
);

	// Combinational hit tests
	logic          bar_on;
	logic          bar_right_zone;
	logic          glyph_on;
	char_code_t    char_code;

	// Stage one to stage two
	pixel_class_t            pix_class;
	logic [`FONT_BIT_W-1:0]  font_bit_idx;
	logic                    tick_s1;

	grid_bars u_grid_bars
	(
		.pix_x          (pix_x),
		.pix_y          (pix_y),
		.bar_on         (bar_on),
		.bar_right_zone (bar_right_zone)
	);

	glyph_map u_glyph_map
	(
		.pix_x          (pix_x),
		.pix_y          (pix_y),
		.num_actual     (num_actual),
		.counter_total  (counter_total),
		.glyph_on       (glyph_on),
		.char_code      (char_code)
	);

	pixel_classifier u_classifier
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.pixel_tick     (pixel_tick),
		.pix_x          (pix_x),
		.pix_y          (pix_y),
		.xm             (xm),
		.ym             (ym),
		.bar_on         (bar_on),
		.bar_right_zone (bar_right_zone),
		.glyph_on       (glyph_on),
		.char_code      (char_code),
		.pix_class      (pix_class),
		.rom_addr       (rom_addr),
		.font_bit_idx   (font_bit_idx),
		.tick_s1        (tick_s1)
	);

	pixel_colorizer u_colorizer
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.pix_class      (pix_class),
		.font_bit_idx   (font_bit_idx),
		.tick_s1        (tick_s1),
		.font_word      (font_word),
		.text_rgb       (text_rgb)
	);

endmodule

//--- bench/tb_calc_painter.sv
// Calculator painter testbench
`include "painter_defines.svh"

module tb_calc_painter
	import color_pkg::*;
();

	// Tests need roughly 650 cycles, readout sweep dominates
	localparam int max_cycles = 2000;

	logic                    clk;
	logic                    rst_n;
	logic                    pixel_tick;
	logic [`PIX_W-1:0]       pix_x;
	logic [`PIX_W-1:0]       pix_y;
	logic [`PIX_W-1:0]       xm;
	logic [`PIX_W-1:0]       ym;
	logic [39:0]             num_actual;
	logic [3:0]              counter_total;
	logic [7:0]              font_word = 8'h00;
	logic [`ROM_ADDR_W-1:0]  rom_addr;
	rgb_t                    text_rgb;

	int cycle_count = 0;
	int error_count = 0;
	int check_count = 0;
	int test_count  = 0;

	// Streaming pixel list
	logic [`PIX_W-1:0]  stream_x [6];
	logic [`PIX_W-1:0]  stream_y [6];
	rgb_t               stream_rgb [6];

	calc_painter_top dut0
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.pixel_tick    (pixel_tick),
		.pix_x         (pix_x),
		.pix_y         (pix_y),
		.xm            (xm),
		.ym            (ym),
		.num_actual    (num_actual),
		.counter_total (counter_total),
		.font_word     (font_word),
		.rom_addr      (rom_addr),
		.text_rgb      (text_rgb)
	);

	always #4 clk = ~clk;  // Period 8

	// Synchronous font ROM stand-in, row pattern from the address
	always @(posedge clk)
		font_word <= rom_addr[7:0] ^ 8'ha5;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles)
		begin
			$display("Timeout: run still going after %0d cycles", cycle_count);
			$display("** FAIL **");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Expected values
	// ------------------------------------------------------------------------
	// Char code then glyph row, four screen lines per row
	function automatic logic [`ROM_ADDR_W-1:0] glyph_addr(input logic [6:0] code,
		input logic [`PIX_W-1:0] y);
		return {code, y[5:2]};
	endfunction

	function automatic rgb_t glyph_rgb(input logic [6:0] code, input logic [`PIX_W-1:0] x,
		input logic [`PIX_W-1:0] y);
		logic [`ROM_ADDR_W-1:0] addr;
		logic [7:0]             row;
		addr = glyph_addr(code, y);
		row  = addr[7:0] ^ 8'ha5;
		return row[3'd7 - x[4:2]] ? white : black;  // Leftmost pixel is MSB
	endfunction

	// ------------------------------------------------------------------------
	// Checks and drivers
	// ------------------------------------------------------------------------
	task automatic check_addr(input logic [`ROM_ADDR_W-1:0] got,
		input logic [`ROM_ADDR_W-1:0] exp);
		check_count++;
		assert (got === exp)
		else
		begin
			$display("ERROR: rom_addr = %h, expected %h", got, exp);
			error_count++;
		end
	endtask

	task automatic check_rgb(input rgb_t got, input rgb_t exp);
		check_count++;
		assert (got === exp)
		else
		begin
			$display("ERROR: text_rgb = %h, expected %h", got, exp);
			error_count++;
		end
	endtask

	task automatic drive_pixel(input logic [`PIX_W-1:0] x, input logic [`PIX_W-1:0] y,
		input logic tick);
		@(posedge clk);
		pix_x      <= x;
		pix_y      <= y;
		pixel_tick <= tick;
	endtask

	task automatic move_cursor(input logic [`PIX_W-1:0] x, input logic [`PIX_W-1:0] y);
		@(posedge clk);
		xm <= x;
		ym <= y;
	endtask

	// One pixel through the pipe: address after E0, colour after E2
	task automatic paint_and_check(input logic [`PIX_W-1:0] x, input logic [`PIX_W-1:0] y,
		input logic [`ROM_ADDR_W-1:0] exp_addr, input rgb_t exp_rgb);
		drive_pixel(x, y, 1'b1);
		@(posedge clk);
		@(negedge clk);
		check_addr(rom_addr, exp_addr);
		@(posedge clk);
		@(posedge clk);
		@(negedge clk);
		check_rgb(text_rgb, exp_rgb);
	endtask

	// Random point inside a tile, code 0 means empty tile
	task automatic check_tile(input int row, input int col, input logic [6:0] code);
		logic [`PIX_W-1:0] x;
		logic [`PIX_W-1:0] y;
		x = `PIX_W'(col * 32 + int'($urandom % 32));
		y = `PIX_W'(row * 64 + int'($urandom % 56));  // Clear of the bar lines
		if (code == 7'h00)
			paint_and_check(x, y, '0, black);
		else
			paint_and_check(x, y, glyph_addr(code, y), glyph_rgb(code, x, y));
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_count++;
		if (error_count == errs_before)
			$display("test %-8s ok", name);
		else
			$display("test %-8s failed, %0d errors", name, error_count - errs_before);
	endtask

	task automatic load_point(input int k, input int x, input int y, input rgb_t rgb);
		stream_x[k]   = `PIX_W'(x);
		stream_y[k]   = `PIX_W'(y);
		stream_rgb[k] = rgb;
	endtask

	// ------------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------------
	task automatic test_reset();
		int errs;
		errs = error_count;
		@(negedge clk);
		check_addr(rom_addr, '0);
		check_rgb(text_rgb, black);
		finish_test("reset", errs);
	endtask

	task automatic test_grid_bars();
		int errs;
		errs = error_count;
		move_cursor(10'd1023, 10'd1023);  // Off screen
		paint_and_check(10'd176, 10'd300, '0, light_blue);  // Bar 0
		paint_and_check(10'd239, 10'd420, '0, light_blue);  // Bar 1, fourth cell
		paint_and_check(10'd365, 10'd300, '0, pink);        // Bar 3 at split
		paint_and_check(10'd491, 10'd300, '0, pink);
		paint_and_check(10'd300, 10'd191, '0, light_blue);  // Top bar
		paint_and_check(10'd400, 10'd191, '0, pink);
		paint_and_check(10'd200, 10'd443, '0, light_blue);  // Short bottom bar
		paint_and_check(10'd178, 10'd300, '0, black);       // Band end open
		paint_and_check(10'd176, 10'd190, '0, black);
		paint_and_check(10'd302, 10'd420, '0, black);       // Bar 2 stops short
		paint_and_check(10'd491, 10'd380, '0, black);
		finish_test("grid", errs);
	endtask

	task automatic test_keypad();
		int errs;
		errs = error_count;
		check_tile(3, 6, 7'h37);
		check_tile(3, 8, 7'h38);
		check_tile(3, 10, 7'h39);
		check_tile(3, 12, 7'h78);  // mul
		check_tile(3, 14, 7'h25);  // div
		check_tile(4, 6, 7'h34);
		check_tile(4, 8, 7'h35);
		check_tile(4, 10, 7'h36);
		check_tile(4, 12, 7'h2b);  // add
		check_tile(4, 14, 7'h2d);  // sub
		check_tile(5, 6, 7'h31);
		check_tile(5, 8, 7'h32);
		check_tile(5, 10, 7'h33);
		check_tile(5, 14, 7'h3d);  // eq
		check_tile(6, 6, 7'h30);
		check_tile(5, 12, 7'h00);  // Hole in keypad
		check_tile(2, 6, 7'h00);   // Above keypad
		finish_test("keypad", errs);
	endtask

	task automatic test_readout();
		int          errs;
		logic [39:0] value;
		logic [6:0]  code;
		errs = error_count;
		for (int ct = 0; ct <= 10; ct++)
		begin
			for (int i = 0; i < 10; i++)
				value[4*i +: 4] = 4'($urandom % 10);  // Random BCD
			@(posedge clk);
			num_actual    <= value;
			counter_total <= 4'(ct);
			for (int i = 0; i < 10; i++)
			begin
				code = (ct > i) ? 7'h30 + {3'b000, value[4*i +: 4]} : 7'h00;
				check_tile(1, 14 - i, code);
			end
		end
		finish_test("readout", errs);
	endtask

	task automatic test_cursor();
		int errs;
		errs = error_count;
		move_cursor(10'd174, 10'd298);
		paint_and_check(10'd176, 10'd300, '0, green);  // Over bar 0
		move_cursor(10'd198, 10'd198);
		paint_and_check(10'd200, 10'd200, '0, green);  // Over the 7 key
		paint_and_check(10'd203, 10'd200, glyph_addr(7'h37, 10'd200),
			glyph_rgb(7'h37, 10'd203, 10'd200));  // Just past the box
		move_cursor(10'd1023, 10'd1023);
		finish_test("cursor", errs);
	endtask

	task automatic test_stream();
		int errs;
		errs = error_count;
		load_point(0, 176, 300, light_blue);
		load_point(1, 200, 200, glyph_rgb(7'h37, 10'd200, 10'd200));
		load_point(2, 365, 300, pink);
		load_point(3, 178, 300, black);
		load_point(4, 448, 200, glyph_rgb(7'h25, 10'd448, 10'd200));
		load_point(5, 491, 300, pink);
		// One pixel per cycle, colour three edges after the drive
		for (int c = 0; c < 9; c++)
		begin
			if (c < 6)
				drive_pixel(stream_x[c], stream_y[c], 1'b1);
			else
				@(posedge clk);
			@(negedge clk);
			if (c >= 3)
				check_rgb(text_rgb, stream_rgb[c - 3]);
		end
		// Unqualified pixels leave the output alone
		for (int c = 0; c < 5; c++)
		begin
			drive_pixel(10'd176, 10'd300, 1'b0);
			@(negedge clk);
			check_rgb(text_rgb, pink);
		end
		paint_and_check(10'd178, 10'd300, '0, black);
		finish_test("stream", errs);
	endtask

	// ------------------------------------------------------------------------
	// Run
	// ------------------------------------------------------------------------
	initial
	begin
		void'($urandom(76));
		clk           = 1'b0;
		rst_n         = 1'b0;
		pixel_tick    = 1'b0;
		pix_x         = '0;
		pix_y         = '0;
		xm            = 10'd1023;
		ym            = 10'd1023;
		num_actual    = '0;
		counter_total = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		test_reset();
		test_grid_bars();
		test_keypad();
		test_readout();
		test_cursor();
		test_stream();

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- sources.f
+incdir+include
source/glyph_pkg.sv
source/color_pkg.sv
source/grid_bars.sv
source/glyph_map.sv
source/pixel_classifier.sv
source/pixel_colorizer.sv
source/calc_painter_top.sv
bench/tb_calc_painter.sv

//--- Makefile
sim:
	verilator --binary --assert -f sources.f --top-module tb_calc_painter
	out="$$(./obj_dir/Vtb_calc_painter)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^\*\* PASS \*\*$$'

clean:
	rm -rf obj_dir

.PHONY: sim clean
